//--- rcc_pkg.sv
`default_nettype none

package rcc_pkg;

  // ==========================================================================
  // counters
  // ==========================================================================

  // every delay and duration counter, so durations stay at or below 15
  localparam int RCC_CNT_W = 4;

  typedef logic [RCC_CNT_W-1:0] rcc_cnt_t;

  // default domain reset hold, in pre_sys_clk cycles
  localparam int RCC_DEF_RST_DURATION = 10;
  // default clock-on delay after a reset release
  localparam int RCC_DEF_CLK_DELAY = 8;

  // ==========================================================================
  // busy vectors
  // ==========================================================================

  // d1: [0] axi bridge, [1] ahb3 bridge, [2] apb3 bridge, [3] flash
  typedef logic [3:0] d1_busy_t;
  // d2: [0] ahb1, [1] ahb2, [2] apb1, [3] apb2 bridges
  typedef logic [3:0] d2_busy_t;
  // d3: [0] ahb4, [1] apb4 bridges
  typedef logic [1:0] d3_busy_t;

  // reset-gated clock enable fsm
  typedef enum logic [1:0] {
    GATE_HOLD = 2'd0,
    GATE_WAIT = 2'd1,
    GATE_RUN  = 2'd2
  } gate_state_t;

endpackage

`default_nettype wire

//--- rcc_sys_rst.sv
`timescale 1ns/100ps
`default_nettype none

module rcc_sys_rst (
  input  wire logic pre_sys_clk,
  input  wire logic rst_n,
  // pad and power sources
  input  wire logic nrst_in,
  input  wire logic pwr_por_rst,
  input  wire logic pwr_bor_rst,
  input  wire logic pwr_vcore_ok,
  // flash / option bytes
  input  wire logic flash_obl_reload,
  input  wire logic obl_done,
  input  wire logic flash_power_ok,
  input  wire logic hsi_rdy,
  // watchdogs, low-power and software resets
  input  wire logic iwdg1_out_rst,
  input  wire logic iwdg2_out_rst,
  input  wire logic wwdg1_out_rst,
  input  wire logic wwdg2_out_rst,
  input  wire logic ww1rsc,
  input  wire logic ww2rsc,
  input  wire logic lpwr1_rst,
  input  wire logic lpwr2_rst,
  input  wire logic cpu1_sftrst,
  input  wire logic cpu2_sftrst,
  // synchronized resets back from the gates
  input  wire logic sys_sync_rst_n,
  input  wire logic d1_sync_rst_n,
  input  wire logic d2_sync_rst_n,
  output logic      sys_rst_n,
  output logic      obl_rst_n,
  output logic      nrst_out,
  output logic      cpu1_sync_rst_n,
  output logic      cpu2_sync_rst_n,
  output logic      d1_bus_sync_rst_n,
  output logic      d2_bus_sync_rst_n,
  output logic      d3_bus_sync_rst_n
);

  logic hw_init_done;
  logic obl_rst;
  logic any_rst_src;

  // ==========================================================================
  // source tree
  // ==========================================================================

  // power up, vcore ok and option bytes loaded
  assign hw_init_done = !pwr_por_rst && pwr_vcore_ok && !flash_obl_reload && obl_done;

  // option byte load still running or reload requested
  assign obl_rst = !obl_done || flash_obl_reload;

  // obl block comes out of reset once por is gone and vcore is up
  assign obl_rst_n = !pwr_por_rst && pwr_vcore_ok;

  // wwdg only reaches the pad when its rsc bit allows it
  assign any_rst_src = obl_rst || pwr_por_rst || pwr_bor_rst
                    || lpwr1_rst || lpwr2_rst
                    || (wwdg1_out_rst && ww1rsc) || (wwdg2_out_rst && ww2rsc)
                    || iwdg1_out_rst || iwdg2_out_rst
                    || cpu1_sftrst || cpu2_sftrst;

  // ==========================================================================
  // registered system reset and pad request
  // ==========================================================================

  always_ff @(posedge pre_sys_clk) begin
    if (!rst_n || !nrst_in || !hw_init_done) begin
      sys_rst_n <= 1'b0;
    end else begin
      // release needs hsi running and flash powered
      sys_rst_n <= hsi_rdy && flash_power_ok;
    end
  end

  always_ff @(posedge pre_sys_clk) begin
    if (!rst_n) begin
      nrst_out <= 1'b0;
    end else begin
      nrst_out <= !any_rst_src;
    end
  end

  // cpu and bus resets
  assign cpu1_sync_rst_n   = sys_sync_rst_n && d1_sync_rst_n && !wwdg1_out_rst;
  assign cpu2_sync_rst_n   = sys_sync_rst_n && d2_sync_rst_n && !wwdg2_out_rst;
  assign d1_bus_sync_rst_n = sys_sync_rst_n && d1_sync_rst_n;
  assign d2_bus_sync_rst_n = sys_sync_rst_n && d2_sync_rst_n;
  assign d3_bus_sync_rst_n = sys_sync_rst_n;

  // cpu1 stays in reset for as long as the system gate holds it
  a_cpu1_under_sys : assert property (
    @(posedge pre_sys_clk) disable iff (!rst_n)
    !sys_sync_rst_n |-> !cpu1_sync_rst_n
  ) else $error("cpu1 released while system in reset");

endmodule

`default_nettype wire

//--- rcc_domain_rst.sv
`timescale 1ns/100ps
`default_nettype none

module rcc_domain_rst import rcc_pkg::*; #(
  parameter int DURATION   = RCC_DEF_RST_DURATION,
  parameter bit WAIT_FLASH = 1'b0
) (
  input  wire logic pre_sys_clk,
  input  wire logic rst_n,
  input  wire logic pwr_ok,
  input  wire logic flash_power_ok,
  output logic      dom_rst_n
);

  localparam rcc_cnt_t DUR = rcc_cnt_t'(DURATION);

  rcc_cnt_t cnt;
  logic     flash_ok;

  // d2 has no flash, so only d1 waits here
  assign flash_ok = flash_power_ok || !WAIT_FLASH;

  // ==========================================================================
  // hold counter
  // ==========================================================================

  always_ff @(posedge pre_sys_clk) begin
    if (!rst_n || !pwr_ok) begin
      // power loss restarts the whole hold time
      cnt       <= '0;
      dom_rst_n <= 1'b0;
    end else begin
      // saturates at the duration
      if (cnt < DUR) begin
        cnt <= cnt + rcc_cnt_t'(1);
      end
      // release one edge after the count is reached
      if (flash_ok) begin
        dom_rst_n <= (cnt == DUR);
      end
    end
  end

  a_cnt_bound : assert property (
    @(posedge pre_sys_clk) disable iff (!rst_n)
    cnt <= DUR
  ) else $error("domain reset counter above duration");

endmodule

`default_nettype wire

//--- rcc_rst_clk_gate.sv
`timescale 1ns/100ps
`default_nettype none

module rcc_rst_clk_gate import rcc_pkg::*; #(
  parameter int DELAY = RCC_DEF_CLK_DELAY
) (
  input  wire logic pre_sys_clk,
  input  wire logic rst_n,
  input  wire logic src_rst_n,
  input  wire logic arcg_on,
  output logic      sync_rst_n,
  output logic      clk_en
);

  // wait ends once the count reaches delay-1, run lands delay edges
  // after sync release
  localparam rcc_cnt_t LAST = rcc_cnt_t'(DELAY - 1);

  gate_state_t state;
  rcc_cnt_t    cnt;

  // ==========================================================================
  // reset register
  // ==========================================================================

  always_ff @(posedge pre_sys_clk) begin
    if (!rst_n) begin
      sync_rst_n <= 1'b0;
    end else begin
      sync_rst_n <= src_rst_n;
    end
  end

  // ==========================================================================
  // clock-on fsm
  // ==========================================================================

  always_ff @(posedge pre_sys_clk) begin
    if (!rst_n || !sync_rst_n) begin
      state <= GATE_HOLD;
      cnt   <= '0;
    end else begin
      case (state)
        GATE_HOLD: begin
          // first edge after release already counts
          state <= GATE_WAIT;
          cnt   <= rcc_cnt_t'(1);
        end
        GATE_WAIT: begin
          if (cnt >= LAST) begin
            state <= GATE_RUN;
          end else begin
            cnt <= cnt + rcc_cnt_t'(1);
          end
        end
        GATE_RUN: begin
          state <= GATE_RUN;
        end
        default: begin
          state <= GATE_HOLD;
        end
      endcase
    end
  end

  // drops in the same cycle as the sync reset
  // free running when gating is off
  assign clk_en = (state == GATE_RUN && sync_rst_n) || !arcg_on;

  a_en_needs_rst : assert property (
    @(posedge pre_sys_clk) disable iff (!rst_n)
    arcg_on && clk_en |-> sync_rst_n
  ) else $error("clock enabled while held in reset");

endmodule

`default_nettype wire

//--- rcc_lp_req.sv
`timescale 1ns/100ps
`default_nettype none

module rcc_lp_req import rcc_pkg::*; (
  input  wire logic     pre_sys_clk,
  input  wire logic     rst_n,
  input  wire logic     sys_sync_rst_n,
  // cpu and d3 sleep state
  input  wire logic     c1_deepsleep,
  input  wire logic     c2_deepsleep,
  input  wire logic     d3_deepsleep,
  // peripheral allocation across cpus
  input  wire logic     c2_per_alloc_d1,
  input  wire logic     c1_per_alloc_d2,
  input  wire d1_busy_t d1_busy,
  input  wire d2_busy_t d2_busy,
  input  wire d3_busy_t d3_busy,
  // wakeup pulses from pwr
  input  wire logic     pwr_d1_wkup,
  input  wire logic     pwr_d2_wkup,
  input  wire logic     pwr_d3_wkup,
  output logic          rcc_pwr_d1_req,
  output logic          rcc_pwr_d2_req,
  output logic          rcc_pwr_d3_req
);

  logic       d1_any_busy;
  logic       d2_any_busy;
  logic       d3_any_busy;
  // bit 0 d1, bit 1 d2, bit 2 d3
  logic [2:0] req_set;
  logic [2:0] wkup;
  logic [2:0] req;

  // ==========================================================================
  // busy aggregation
  // ==========================================================================

  assign d1_any_busy = |d1_busy;
  assign d2_any_busy = |d2_busy;
  // d3 carries the traffic of both other domains
  assign d3_any_busy = d1_any_busy || d2_any_busy || (|d3_busy);

  // owner stopped, other cpu stopped or owns nothing there, domain idle
  assign req_set[0] = c1_deepsleep && (c2_deepsleep || !c2_per_alloc_d1) && !d1_any_busy;
  assign req_set[1] = c2_deepsleep && (c1_deepsleep || !c1_per_alloc_d2) && !d2_any_busy;
  // everything asleep and nothing in flight
  assign req_set[2] = c1_deepsleep && c2_deepsleep && d3_deepsleep && !d3_any_busy;

  assign wkup = {pwr_d3_wkup, pwr_d2_wkup, pwr_d1_wkup};

  // ==========================================================================
  // request latches
  // ==========================================================================

  always_ff @(posedge pre_sys_clk) begin
    if (!rst_n || !sys_sync_rst_n) begin
      req <= '0;
    end else begin
      // set wins over a wakeup in the same cycle
      req <= req_set | (req & ~wkup);
    end
  end

  assign rcc_pwr_d1_req = req[0];
  assign rcc_pwr_d2_req = req[1];
  assign rcc_pwr_d3_req = req[2];

endmodule

`default_nettype wire

//--- rcc_rst_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module rcc_rst_ctrl_top import rcc_pkg::*; #(
  parameter int D1_RST_DURATION               = RCC_DEF_RST_DURATION,
  parameter int D2_RST_DURATION               = RCC_DEF_RST_DURATION,
  parameter int CLK_ON_AFTER_SYS_RST_RELEASE  = RCC_DEF_CLK_DELAY,
  parameter int CLK_ON_AFTER_D1_RST_RELEASE   = RCC_DEF_CLK_DELAY,
  parameter int CLK_ON_AFTER_D2_RST_RELEASE   = RCC_DEF_CLK_DELAY,
  parameter int CLK_ON_AFTER_CPU1_RST_RELEASE = RCC_DEF_CLK_DELAY,
  parameter int CLK_ON_AFTER_CPU2_RST_RELEASE = RCC_DEF_CLK_DELAY
) (
  input  wire logic     pre_sys_clk,
  input  wire logic     rst_n,
  // reset sources
  input  wire logic     nrst_in,
  input  wire logic     pwr_por_rst,
  input  wire logic     pwr_bor_rst,
  input  wire logic     pwr_vcore_ok,
  input  wire logic     flash_obl_reload,
  input  wire logic     obl_done,
  input  wire logic     flash_power_ok,
  input  wire logic     hsi_rdy,
  input  wire logic     iwdg1_out_rst,
  input  wire logic     iwdg2_out_rst,
  input  wire logic     wwdg1_out_rst,
  input  wire logic     wwdg2_out_rst,
  input  wire logic     ww1rsc,
  input  wire logic     ww2rsc,
  input  wire logic     lpwr1_rst,
  input  wire logic     lpwr2_rst,
  input  wire logic     cpu1_sftrst,
  input  wire logic     cpu2_sftrst,
  // domain power and clock gating
  input  wire logic     pwr_d1_ok,
  input  wire logic     pwr_d2_ok,
  input  wire logic     rcc_arcg_on,
  // low-power inputs
  input  wire logic     c1_deepsleep,
  input  wire logic     c2_deepsleep,
  input  wire logic     d3_deepsleep,
  input  wire logic     c2_per_alloc_d1,
  input  wire logic     c1_per_alloc_d2,
  input  wire d1_busy_t d1_busy,
  input  wire d2_busy_t d2_busy,
  input  wire d3_busy_t d3_busy,
  input  wire logic     pwr_d1_wkup,
  input  wire logic     pwr_d2_wkup,
  input  wire logic     pwr_d3_wkup,
  // resets
  output logic          sys_sync_rst_n,
  output logic          d1_sync_rst_n,
  output logic          d2_sync_rst_n,
  output logic          rcc_obl_sync_rst_n,
  output logic          cpu1_sync_rst_n,
  output logic          cpu2_sync_rst_n,
  output logic          d1_bus_sync_rst_n,
  output logic          d2_bus_sync_rst_n,
  output logic          d3_bus_sync_rst_n,
  output logic          nrst_out,
  // clock enables
  output logic          sys_clk_en,
  output logic          obl_clk_en,
  output logic          d1_clk_en,
  output logic          d2_clk_en,
  output logic          cpu1_clk_en,
  output logic          cpu2_clk_en,
  // low-power requests
  output logic          rcc_pwr_d1_req,
  output logic          rcc_pwr_d2_req,
  output logic          rcc_pwr_d3_req
);

  // unsynchronized releases into the gates
  logic sys_rst_n;
  logic obl_rst_n;
  logic d1_rst_n;
  logic d2_rst_n;

  // ==========================================================================
  // system reset tree
  // ==========================================================================

  rcc_sys_rst u_sys_rst (
    .pre_sys_clk       (pre_sys_clk),
    .rst_n             (rst_n),
    .nrst_in           (nrst_in),
    .pwr_por_rst       (pwr_por_rst),
    .pwr_bor_rst       (pwr_bor_rst),
    .pwr_vcore_ok      (pwr_vcore_ok),
    .flash_obl_reload  (flash_obl_reload),
    .obl_done          (obl_done),
    .flash_power_ok    (flash_power_ok),
    .hsi_rdy           (hsi_rdy),
    .iwdg1_out_rst     (iwdg1_out_rst),
    .iwdg2_out_rst     (iwdg2_out_rst),
    .wwdg1_out_rst     (wwdg1_out_rst),
    .wwdg2_out_rst     (wwdg2_out_rst),
    .ww1rsc            (ww1rsc),
    .ww2rsc            (ww2rsc),
    .lpwr1_rst         (lpwr1_rst),
    .lpwr2_rst         (lpwr2_rst),
    .cpu1_sftrst       (cpu1_sftrst),
    .cpu2_sftrst       (cpu2_sftrst),
    .sys_sync_rst_n    (sys_sync_rst_n),
    .d1_sync_rst_n     (d1_sync_rst_n),
    .d2_sync_rst_n     (d2_sync_rst_n),
    .sys_rst_n         (sys_rst_n),
    .obl_rst_n         (obl_rst_n),
    .nrst_out          (nrst_out),
    .cpu1_sync_rst_n   (cpu1_sync_rst_n),
    .cpu2_sync_rst_n   (cpu2_sync_rst_n),
    .d1_bus_sync_rst_n (d1_bus_sync_rst_n),
    .d2_bus_sync_rst_n (d2_bus_sync_rst_n),
    .d3_bus_sync_rst_n (d3_bus_sync_rst_n)
  );

  // ==========================================================================
  // domain releases
  // ==========================================================================

  // flash sits in d1
  rcc_domain_rst #(.DURATION(D1_RST_DURATION), .WAIT_FLASH(1'b1)) u_d1_rst (
    .pre_sys_clk    (pre_sys_clk),
    .rst_n          (rst_n),
    .pwr_ok         (pwr_d1_ok),
    .flash_power_ok (flash_power_ok),
    .dom_rst_n      (d1_rst_n)
  );

  rcc_domain_rst #(.DURATION(D2_RST_DURATION), .WAIT_FLASH(1'b0)) u_d2_rst (
    .pre_sys_clk    (pre_sys_clk),
    .rst_n          (rst_n),
    .pwr_ok         (pwr_d2_ok),
    .flash_power_ok (flash_power_ok),
    .dom_rst_n      (d2_rst_n)
  );

  // ==========================================================================
  // reset-gated clock enables
  // ==========================================================================

  rcc_rst_clk_gate #(.DELAY(CLK_ON_AFTER_SYS_RST_RELEASE)) u_sys_gate (
    .pre_sys_clk (pre_sys_clk),
    .rst_n       (rst_n),
    .src_rst_n   (sys_rst_n),
    .arcg_on     (rcc_arcg_on),
    .sync_rst_n  (sys_sync_rst_n),
    .clk_en      (sys_clk_en)
  );

  // obl block shares the system delay
  rcc_rst_clk_gate #(.DELAY(CLK_ON_AFTER_SYS_RST_RELEASE)) u_obl_gate (
    .pre_sys_clk (pre_sys_clk),
    .rst_n       (rst_n),
    .src_rst_n   (obl_rst_n),
    .arcg_on     (rcc_arcg_on),
    .sync_rst_n  (rcc_obl_sync_rst_n),
    .clk_en      (obl_clk_en)
  );

  rcc_rst_clk_gate #(.DELAY(CLK_ON_AFTER_D1_RST_RELEASE)) u_d1_gate (
    .pre_sys_clk (pre_sys_clk),
    .rst_n       (rst_n),
    .src_rst_n   (d1_rst_n),
    .arcg_on     (rcc_arcg_on),
    .sync_rst_n  (d1_sync_rst_n),
    .clk_en      (d1_clk_en)
  );

  rcc_rst_clk_gate #(.DELAY(CLK_ON_AFTER_D2_RST_RELEASE)) u_d2_gate (
    .pre_sys_clk (pre_sys_clk),
    .rst_n       (rst_n),
    .src_rst_n   (d2_rst_n),
    .arcg_on     (rcc_arcg_on),
    .sync_rst_n  (d2_sync_rst_n),
    .clk_en      (d2_clk_en)
  );

  // cpu resets are already synchronous, only the enable is taken
  rcc_rst_clk_gate #(.DELAY(CLK_ON_AFTER_CPU1_RST_RELEASE)) u_cpu1_gate (
    .pre_sys_clk (pre_sys_clk),
    .rst_n       (rst_n),
    .src_rst_n   (cpu1_sync_rst_n),
    .arcg_on     (rcc_arcg_on),
    .sync_rst_n  (),
    .clk_en      (cpu1_clk_en)
  );

  rcc_rst_clk_gate #(.DELAY(CLK_ON_AFTER_CPU2_RST_RELEASE)) u_cpu2_gate (
    .pre_sys_clk (pre_sys_clk),
    .rst_n       (rst_n),
    .src_rst_n   (cpu2_sync_rst_n),
    .arcg_on     (rcc_arcg_on),
    .sync_rst_n  (),
    .clk_en      (cpu2_clk_en)
  );

  // ==========================================================================
  // low-power requests
  // ==========================================================================

  rcc_lp_req u_lp_req (
    .pre_sys_clk     (pre_sys_clk),
    .rst_n           (rst_n),
    .sys_sync_rst_n  (sys_sync_rst_n),
    .c1_deepsleep    (c1_deepsleep),
    .c2_deepsleep    (c2_deepsleep),
    .d3_deepsleep    (d3_deepsleep),
    .c2_per_alloc_d1 (c2_per_alloc_d1),
    .c1_per_alloc_d2 (c1_per_alloc_d2),
    .d1_busy         (d1_busy),
    .d2_busy         (d2_busy),
    .d3_busy         (d3_busy),
    .pwr_d1_wkup     (pwr_d1_wkup),
    .pwr_d2_wkup     (pwr_d2_wkup),
    .pwr_d3_wkup     (pwr_d3_wkup),
    .rcc_pwr_d1_req  (rcc_pwr_d1_req),
    .rcc_pwr_d2_req  (rcc_pwr_d2_req),
    .rcc_pwr_d3_req  (rcc_pwr_d3_req)
  );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_NS    = 2,
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  // free running pre_sys_clk, 4 ns period
  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

  // release 1 ns after an edge, like the other inputs
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb_rcc_rst_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rcc_rst_ctrl import rcc_pkg::*; ;

  // ==========================================================================
  // input and output bit maps for the table
  // ==========================================================================

  localparam logic [20:0] I_NRST     = 21'h000001;
  localparam logic [20:0] I_POR      = 21'h000002;
  localparam logic [20:0] I_BOR      = 21'h000004;
  localparam logic [20:0] I_VCORE    = 21'h000008;
  localparam logic [20:0] I_RELOAD   = 21'h000010;
  localparam logic [20:0] I_OBL_DONE = 21'h000020;
  localparam logic [20:0] I_FLASH    = 21'h000040;
  localparam logic [20:0] I_HSI      = 21'h000080;
  localparam logic [20:0] I_IWDG1    = 21'h000100;
  localparam logic [20:0] I_IWDG2    = 21'h000200;
  localparam logic [20:0] I_WWDG1    = 21'h000400;
  localparam logic [20:0] I_WWDG2    = 21'h000800;
  localparam logic [20:0] I_WW1RSC   = 21'h001000;
  localparam logic [20:0] I_WW2RSC   = 21'h002000;
  localparam logic [20:0] I_LPWR1    = 21'h004000;
  localparam logic [20:0] I_LPWR2    = 21'h008000;
  localparam logic [20:0] I_SFT1     = 21'h010000;
  localparam logic [20:0] I_SFT2     = 21'h020000;
  localparam logic [20:0] I_D1_OK    = 21'h040000;
  localparam logic [20:0] I_D2_OK    = 21'h080000;
  localparam logic [20:0] I_ARCG     = 21'h100000;
  // nrst_in, vcore, obl done, flash, hsi and gating on
  localparam logic [20:0] CLEAN      = I_NRST | I_VCORE | I_OBL_DONE | I_FLASH | I_HSI
                                     | I_ARCG;
  localparam logic [20:0] FULL       = CLEAN | I_D1_OK | I_D2_OK;

  localparam logic [15:0] O_SYS    = 16'h0001;
  localparam logic [15:0] O_D1     = 16'h0002;
  localparam logic [15:0] O_D2     = 16'h0004;
  localparam logic [15:0] O_OBL    = 16'h0008;
  localparam logic [15:0] O_CPU1   = 16'h0010;
  localparam logic [15:0] O_CPU2   = 16'h0020;
  localparam logic [15:0] O_D1BUS  = 16'h0040;
  localparam logic [15:0] O_D2BUS  = 16'h0080;
  localparam logic [15:0] O_D3BUS  = 16'h0100;
  localparam logic [15:0] O_NRST   = 16'h0200;
  localparam logic [15:0] O_SYSEN  = 16'h0400;
  localparam logic [15:0] O_OBLEN  = 16'h0800;
  localparam logic [15:0] O_D1EN   = 16'h1000;
  localparam logic [15:0] O_D2EN   = 16'h2000;
  localparam logic [15:0] O_CPU1EN = 16'h4000;
  localparam logic [15:0] O_CPU2EN = 16'h8000;
  localparam logic [15:0] O_ALL    = 16'hFFFF;
  localparam logic [15:0] O_EN_ALL = 16'hFC00;

  localparam int RAND_STEPS = 64;

  logic pre_sys_clk;
  logic rst_n;
  logic nrst_in, pwr_por_rst, pwr_bor_rst, pwr_vcore_ok;
  logic flash_obl_reload, obl_done, flash_power_ok, hsi_rdy;
  logic iwdg1_out_rst, iwdg2_out_rst, wwdg1_out_rst, wwdg2_out_rst;
  logic ww1rsc, ww2rsc, lpwr1_rst, lpwr2_rst, cpu1_sftrst, cpu2_sftrst;
  logic pwr_d1_ok, pwr_d2_ok, rcc_arcg_on;
  logic c1_deepsleep, c2_deepsleep, d3_deepsleep;
  logic c2_per_alloc_d1, c1_per_alloc_d2;
  d1_busy_t d1_busy;
  d2_busy_t d2_busy;
  d3_busy_t d3_busy;
  logic pwr_d1_wkup, pwr_d2_wkup, pwr_d3_wkup;

  logic sys_sync_rst_n, d1_sync_rst_n, d2_sync_rst_n, rcc_obl_sync_rst_n;
  logic cpu1_sync_rst_n, cpu2_sync_rst_n;
  logic d1_bus_sync_rst_n, d2_bus_sync_rst_n, d3_bus_sync_rst_n, nrst_out;
  logic sys_clk_en, obl_clk_en, d1_clk_en, d2_clk_en, cpu1_clk_en, cpu2_clk_en;
  logic rcc_pwr_d1_req, rcc_pwr_d2_req, rcc_pwr_d3_req;
  logic [15:0] out_vec;

  // scenario table
  logic [20:0] row_in [64];
  int          row_wait [64];
  logic [15:0] row_exp [64];
  logic [15:0] row_mask [64];
  string       row_name [64];
  int          n_rows;

  int          tests;
  int          failed;
  int          mismatches;
  int          limit_ns;
  logic [31:0] seed;

  tb_clk_gen clk_gen_i (
    .clk   (pre_sys_clk),
    .rst_n (rst_n)
  );

  rcc_rst_ctrl_top dut_i (.*);

  assign out_vec = {cpu2_clk_en, cpu1_clk_en, d2_clk_en, d1_clk_en, obl_clk_en, sys_clk_en,
                    nrst_out, d3_bus_sync_rst_n, d2_bus_sync_rst_n, d1_bus_sync_rst_n,
                    cpu2_sync_rst_n, cpu1_sync_rst_n, rcc_obl_sync_rst_n,
                    d2_sync_rst_n, d1_sync_rst_n, sys_sync_rst_n};

  function automatic string out_name(input int b);
    case (b)
      0: return "sys_sync_rst_n";
      1: return "d1_sync_rst_n";
      2: return "d2_sync_rst_n";
      3: return "rcc_obl_sync_rst_n";
      4: return "cpu1_sync_rst_n";
      5: return "cpu2_sync_rst_n";
      6: return "d1_bus_sync_rst_n";
      7: return "d2_bus_sync_rst_n";
      8: return "d3_bus_sync_rst_n";
      9: return "nrst_out";
      10: return "sys_clk_en";
      11: return "obl_clk_en";
      12: return "d1_clk_en";
      13: return "d2_clk_en";
      14: return "cpu1_clk_en";
      default: return "cpu2_clk_en";
    endcase
  endfunction

  task automatic drive_sources(input logic [20:0] v);
    nrst_in = v[0];
    pwr_por_rst = v[1];
    pwr_bor_rst = v[2];
    pwr_vcore_ok = v[3];
    flash_obl_reload = v[4];
    obl_done = v[5];
    flash_power_ok = v[6];
    hsi_rdy = v[7];
    iwdg1_out_rst = v[8];
    iwdg2_out_rst = v[9];
    wwdg1_out_rst = v[10];
    wwdg2_out_rst = v[11];
    ww1rsc = v[12];
    ww2rsc = v[13];
    lpwr1_rst = v[14];
    lpwr2_rst = v[15];
    cpu1_sftrst = v[16];
    cpu2_sftrst = v[17];
    pwr_d1_ok = v[18];
    pwr_d2_ok = v[19];
    rcc_arcg_on = v[20];
  endtask

  task automatic add_row(input string name, input logic [20:0] v, input int w,
                         input logic [15:0] e, input logic [15:0] m);
    row_name[n_rows] = name;
    row_in[n_rows] = v;
    row_wait[n_rows] = w;
    row_exp[n_rows] = e;
    row_mask[n_rows] = m;
    n_rows = n_rows + 1;
  endtask

  // ==========================================================================
  // scenario rows with expected values from the release and gate timing rules
  // ==========================================================================

  task automatic build_table();
    logic [20:0] pad_src [13];
    logic [15:0] pad_exp [13];
    pad_src = '{I_POR, I_BOR, I_RELOAD, I_OBL_DONE, I_IWDG1, I_IWDG2, I_WWDG1 | I_WW1RSC,
                I_WWDG2 | I_WW2RSC, I_WWDG2, I_LPWR1, I_LPWR2, I_SFT1, I_SFT2};
    // wwdg2 alone has rsc clear so the pad stays released
    pad_exp = '{16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, O_NRST,
                16'h0, 16'h0, 16'h0, 16'h0};
    // sys release two edges after clean sources and enables eight later
    add_row("held", I_POR | I_ARCG, 2, 16'h0, O_ALL);
    add_row("clean obl", CLEAN, 1, O_OBL | O_NRST, O_SYS | O_OBL | O_NRST | O_D3BUS);
    add_row("sys release", CLEAN, 1, O_SYS | O_OBL | O_NRST | O_D3BUS,
            O_SYS | O_OBL | O_NRST | O_D3BUS | O_SYSEN | O_OBLEN | O_CPU1 | O_D1BUS);
    add_row("en still off", CLEAN, RCC_DEF_CLK_DELAY - 2, 16'h0, O_SYSEN | O_OBLEN);
    add_row("obl en", CLEAN, 1, O_OBLEN, O_SYSEN | O_OBLEN);
    add_row("sys en", CLEAN, 1, O_SYSEN | O_OBLEN, O_SYSEN | O_OBLEN);
    // d2 counts the duration and then passes the gate register
    add_row("d2 counting", CLEAN | I_D2_OK, RCC_DEF_RST_DURATION + 1, 16'h0,
            O_D2 | O_D2BUS | O_CPU2);
    add_row("d2 release", CLEAN | I_D2_OK, 1, O_D2 | O_D2BUS | O_CPU2,
            O_D2 | O_D2BUS | O_CPU2);
    add_row("d2 en", CLEAN | I_D2_OK, RCC_DEF_CLK_DELAY, O_D2EN, O_D2EN | O_CPU2EN);
    add_row("cpu2 en", CLEAN | I_D2_OK, 1, O_D2EN | O_CPU2EN, O_D2EN | O_CPU2EN);
    // no flash power also holds the system reset
    add_row("d1 no flash", (FULL & ~I_FLASH), 15, O_D2, O_D1 | O_SYS | O_D2);
    add_row("flash up", FULL, 1, 16'h0, O_D1 | O_SYS);
    add_row("d1 release", FULL, 1, O_D1 | O_SYS | O_CPU1 | O_D1BUS,
            O_D1 | O_SYS | O_CPU1 | O_D1BUS | O_D1EN);
    add_row("d1 en", FULL, RCC_DEF_CLK_DELAY, O_D1EN | O_SYSEN, O_D1EN | O_SYSEN | O_CPU1EN);
    add_row("cpu1 en", FULL, 1, O_D1EN | O_SYSEN | O_CPU1EN, O_D1EN | O_SYSEN | O_CPU1EN);
    // cpu and bus resets
    add_row("wwdg1 no rsc", FULL | I_WWDG1, 1, O_D1BUS | O_NRST,
            O_CPU1 | O_D1BUS | O_NRST | O_CPU1EN);
    add_row("wwdg1 gone", FULL, 1, O_CPU1, O_CPU1 | O_CPU1EN);
    add_row("cpu1 en again", FULL, RCC_DEF_CLK_DELAY, O_CPU1 | O_CPU1EN, O_CPU1 | O_CPU1EN);
    add_row("d1 power drop", (FULL & ~I_D1_OK), 2, 16'h0, O_D1 | O_D1EN | O_CPU1);
    add_row("d1 power back", FULL, RCC_DEF_RST_DURATION + 2, O_D1, O_D1);
    // low nrst_in holds the system reset but never drives the pad request
    add_row("nrst in low", (FULL & ~I_NRST), 2, O_NRST, O_SYS | O_NRST | O_D3BUS);
    // pad request follows each source by one edge
    for (int i = 0; i < 13; i++) begin
      add_row($sformatf("pad src %0d", i), FULL ^ pad_src[i], 1, pad_exp[i], O_NRST);
      add_row($sformatf("pad clr %0d", i), FULL, 1, O_NRST, O_NRST);
    end
    add_row("recover", FULL, 40, O_ALL, O_ALL);
    // gating off keeps enables up with everything in reset
    add_row("gating off", I_POR, 15, O_EN_ALL, O_ALL);
    add_row("recover again", FULL, 40, O_ALL, O_ALL);
  endtask

  task automatic check_row(input int r);
    int bad;
    bad = 0;
    for (int b = 0; b < 16; b++) begin
      if (row_mask[r][b] && (out_vec[b] !== row_exp[r][b])) begin
        $display("MISMATCH t=%0t %s exp=%b act=%b", $time, out_name(b),
                 row_exp[r][b], out_vec[b]);
        bad = bad + 1;
      end
    end
    tests = tests + 1;
    mismatches = mismatches + bad;
    if (bad != 0) begin
      failed = failed + 1;
      $display("test %0d %s: fail", r, row_name[r]);
    end else begin
      $display("test %0d %s: pass", r, row_name[r]);
    end
  endtask

  // ==========================================================================
  // random low-power requests against the set and clear rules
  // ==========================================================================

  task automatic run_lp_random();
    logic [31:0] r;
    logic [2:0]  set_v;
    logic [2:0]  wk;
    logic [2:0]  exp_req;
    logic [2:0]  act;
    logic        b1, b2, b3;
    int          bad;
    bad = 0;
    // all sleep inputs were low so far
    exp_req = 3'b000;
    for (int s = 0; s < RAND_STEPS; s++) begin
      r = $random(seed);
      c1_deepsleep = r[0] | r[25];
      c2_deepsleep = r[1] | r[26];
      d3_deepsleep = r[2] | r[27];
      c2_per_alloc_d1 = r[3];
      c1_per_alloc_d2 = r[4];
      d1_busy = r[5] ? r[9:6] : 4'h0;
      d2_busy = r[10] ? r[14:11] : 4'h0;
      d3_busy = r[15] ? r[17:16] : 2'h0;
      wk = r[20:18] & r[30:28];
      {pwr_d3_wkup, pwr_d2_wkup, pwr_d1_wkup} = wk;
      b1 = (d1_busy != 4'h0);
      b2 = (d2_busy != 4'h0);
      b3 = b1 || b2 || (d3_busy != 2'h0);
      set_v[0] = c1_deepsleep && (c2_deepsleep || !c2_per_alloc_d1) && !b1;
      set_v[1] = c2_deepsleep && (c1_deepsleep || !c1_per_alloc_d2) && !b2;
      set_v[2] = c1_deepsleep && c2_deepsleep && d3_deepsleep && !b3;
      // set wins over a wakeup and a request holds without either
      for (int d = 0; d < 3; d++) begin
        if (set_v[d]) begin
          exp_req[d] = 1'b1;
        end else if (wk[d]) begin
          exp_req[d] = 1'b0;
        end
      end
      @(posedge pre_sys_clk);
      #1;
      act = {rcc_pwr_d3_req, rcc_pwr_d2_req, rcc_pwr_d1_req};
      for (int d = 0; d < 3; d++) begin
        if (act[d] !== exp_req[d]) begin
          $display("MISMATCH t=%0t rcc_pwr_d%0d_req exp=%b act=%b", $time, d + 1,
                   exp_req[d], act[d]);
          bad = bad + 1;
        end
      end
    end
    tests = tests + 1;
    mismatches = mismatches + bad;
    if (bad != 0) begin
      failed = failed + 1;
      $display("test lp random: fail");
    end else begin
      $display("test lp random: pass");
    end
  endtask

  // watchdog armed once the table length is known
  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("timeout, the run did not finish within %0d ns", limit_ns);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int total;
    seed = 32'h1cb5;
    tests = 0;
    failed = 0;
    mismatches = 0;
    n_rows = 0;
    limit_ns = 0;
    drive_sources(I_POR | I_ARCG);
    {c1_deepsleep, c2_deepsleep, d3_deepsleep} = 3'b000;
    {c2_per_alloc_d1, c1_per_alloc_d2} = 2'b00;
    d1_busy = '0;
    d2_busy = '0;
    d3_busy = '0;
    {pwr_d1_wkup, pwr_d2_wkup, pwr_d3_wkup} = 3'b000;
    build_table();
    total = RAND_STEPS + 100;
    for (int i = 0; i < n_rows; i++) begin
      total = total + row_wait[i];
    end
    limit_ns = total * 4;
    wait (rst_n === 1'b1);
    @(posedge pre_sys_clk);
    #1;
    for (int i = 0; i < n_rows; i++) begin
      drive_sources(row_in[i]);
      repeat (row_wait[i]) @(posedge pre_sys_clk);
      #1;
      check_row(i);
    end
    run_lp_random();
    $display("tests %0d, failed %0d, mismatches %0d", tests, failed, mismatches);
    if (failed == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
rcc_pkg.sv
rcc_sys_rst.sv
rcc_domain_rst.sv
rcc_rst_clk_gate.sv
rcc_lp_req.sv
rcc_rst_ctrl_top.sv
tb_clk_gen.sv
tb_rcc_rst_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_rcc_rst_ctrl \
  -f compile.f \
  -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output="$(./obj_dir/sim_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
